// ==== src.f ====
hw/cmd_pkg.sv
hw/spi_pkg.sv
hw/cmd_receiver.sv
hw/spi_sequencer.sv
hw/status_regs.sv
hw/cmd_processor.sv
testbench/tb_clk_gen.sv
testbench/tb_cmd_processor.sv

// ==== Bender.yml ====
package:
  name: cmd_processor

sources:
  - hw/cmd_pkg.sv
  - hw/spi_pkg.sv
  - hw/cmd_receiver.sv
  - hw/spi_sequencer.sv
  - hw/status_regs.sv
  - hw/cmd_processor.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_cmd_processor.sv

// ==== testbench/tb_cmd_processor.sv ====
//------------------------------
// tb_cmd_processor
// table driven testbench for the command processor,
// with an spi master model and random output back-pressure
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_cmd_processor;

	import cmd_pkg::*;
	import spi_pkg::*;

	localparam int    NUM_ROWS       = 13;
	localparam int    TIMEOUT_CYCLES = NUM_ROWS * 200;
	localparam word_t VERSION_WORD   = 32'd12;  // firmware version 12

	logic                      clk;
	logic                      rstn;
	logic                      i_s_valid;
	byte_t                     i_s_data;
	logic                      o_s_ready;
	logic                      o_m_valid;
	word_t                     o_m_data;
	logic [KEEP_BITS-1:0]      o_m_keep;
	logic                      o_m_last;
	logic                      i_m_ready;
	byte_t                     o_spi_tx;
	logic                      o_spi_tx_dv;
	logic                      i_spi_tx_ready;
	logic                      i_spi_rx_dv;
	byte_t                     i_spi_rx;
	logic [NUM_CHIPS-1:0]      o_spi_cs;
	spi_mode_t                 o_spi_mode;
	logic                      o_spi_rst_n;
	chip_sel_t                 o_spi_miso_sel;
	logic [NUM_ADC_INPUTS-1:0] i_overrange;

	// ------------------------------
	// stimulus table and bookkeeping
	string       row_name  [NUM_ROWS];
	logic [63:0] row_bytes [NUM_ROWS];  // byte 0 in the top bits
	bit          row_resp  [NUM_ROWS];  // response expected
	int          ovr_cycles [NUM_ADC_INPUTS] = '{5, 9, 0, 17};

	int        num_loaded    = 0;
	int        expected_resp = 0;
	int        errors        = 0;
	int        checks        = 0;
	int        tests_run     = 0;
	int        tests_failed  = 0;
	int        handshakes    = 0;
	int        cycle_count   = 0;
	bit        test_ok       = 1'b1;
	bit        rst_seen      = 1'b0;
	word_t     resp_q [$];
	byte_t     sent_bytes [$];
	byte_t     sent_cs [$];
	chip_sel_t sent_sel [$];
	byte_t     last_reply;
	logic [31:0] rng;
	bit        stalled;
	word_t     held_word;
	int        reply_wait;

	tb_clk_gen i_tb_clk_gen (
		.clk  (clk),
		.rstn (rstn)
	);

	cmd_processor i_cmd_processor (
		.clk            (clk),
		.rstn           (rstn),
		.i_s_valid      (i_s_valid),
		.i_s_data       (i_s_data),
		.o_s_ready      (o_s_ready),
		.o_m_valid      (o_m_valid),
		.o_m_data       (o_m_data),
		.o_m_keep       (o_m_keep),
		.o_m_last       (o_m_last),
		.i_m_ready      (i_m_ready),
		.o_spi_tx       (o_spi_tx),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx       (i_spi_rx),
		.o_spi_cs       (o_spi_cs),
		.o_spi_mode     (o_spi_mode),
		.o_spi_rst_n    (o_spi_rst_n),
		.o_spi_miso_sel (o_spi_miso_sel),
		.i_overrange    (i_overrange)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic byte_t row_byte(input logic [63:0] bytes, input int pos);
		return bytes[63 - 8*pos -: 8];
	endfunction

	task automatic flag_error(input string what);
		$display("%s", what);
		errors++;
		test_ok = 1'b0;
	endtask

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, exp, act);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic compare_byte(input string name, input byte_t exp, input byte_t act);
		checks++;
		if (exp !== act) begin
			$display("MISMATCH %s: expected 0x%h, actual 0x%h", name, exp, act);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic compare_mode(input string name, input spi_mode_t exp,
			input spi_mode_t act);
		checks++;
		if (exp !== act) begin
			$display("MISMATCH %s: expected mode %0d, actual mode %0d", name, exp, act);
			errors++;
			test_ok = 1'b0;
		end
	endtask

	task automatic add_row(input string name, input logic [63:0] bytes, input bit resp);
		row_name[num_loaded]  = name;
		row_bytes[num_loaded] = bytes;
		row_resp[num_loaded]  = resp;
		num_loaded++;
		if (resp)
			expected_resp++;
	endtask

	task automatic fill_table();
		add_row("version",       64'h02_00_00_00_00_00_00_00, 1'b1);
		add_row("mode_3",        64'h04_07_00_00_00_00_00_00, 1'b1);
		add_row("spi_1b_cs0",    64'h03_00_a1_b2_c3_d4_00_01, 1'b1);
		add_row("spi_2b_cs5",    64'h03_05_11_22_33_44_00_02, 1'b1);
		add_row("spi_3b_cs2",    64'h03_02_5a_6b_7c_8d_00_03, 1'b1);
		add_row("spi_4b_cs7",    64'h03_07_f0_0f_cc_33_00_04, 1'b1);
		add_row("ovr_0",         64'h07_00_00_00_00_00_00_00, 1'b1);
		add_row("ovr_1",         64'h07_01_00_00_00_00_00_00, 1'b1);
		add_row("ovr_2",         64'h07_02_00_00_00_00_00_00, 1'b1);
		add_row("ovr_3",         64'h07_ff_00_00_00_00_00_00, 1'b1);  // upper bits ignored
		add_row("unknown_op",    64'h09_12_34_56_78_9a_bc_de, 1'b0);
		add_row("version_again", 64'h02_00_00_00_00_00_00_00, 1'b1);
		add_row("mode_0",        64'h04_fc_00_00_00_00_00_00, 1'b1);
	endtask

	// called at a falling edge, returns at one
	task automatic send_frame(input logic [63:0] bytes);
		int b;
		for (b = 0; b < FRAME_BYTES; b++) begin
			i_s_valid = 1'b1;
			i_s_data  = row_byte(bytes, b);
			while (!o_s_ready)
				@(negedge clk);
			@(negedge clk);  // byte taken on the rising edge
		end
		i_s_valid = 1'b0;
	endtask

	task automatic drive_overrange(input int idx, input int cycles);
		if (cycles > 0) begin
			i_overrange[idx] = 1'b1;
			repeat (cycles) @(negedge clk);
			i_overrange[idx] = 1'b0;
		end
	endtask

	task automatic check_spi(input string name, input logic [63:0] fb, input word_t got);
		byte_t     sel_byte;
		chip_sel_t chip;
		byte_t     cnt;
		int        nbytes;
		int        i;
		sel_byte = row_byte(fb, 1);
		chip     = sel_byte[2:0];
		cnt      = row_byte(fb, 7);
		nbytes = (cnt == 0) ? 1 : ((cnt > MAX_SPI_BYTES) ? MAX_SPI_BYTES : cnt);
		if (sent_bytes.size() != nbytes)
			flag_error($sformatf("%s: spi master got %0d bytes instead of %0d",
				name, sent_bytes.size(), nbytes));
		for (i = 0; i < nbytes && i < sent_bytes.size(); i++) begin
			compare_byte(name, row_byte(fb, 2 + i), sent_bytes[i]);
			compare_byte(name, ~(8'd1 << chip), sent_cs[i]);  // one cs low
			compare_byte(name, byte_t'(chip), byte_t'(sent_sel[i]));
		end
		compare_word(name, word_t'(last_reply), got);
	endtask

	task automatic run_test(input int idx);
		string       name;
		logic [63:0] fb;
		byte_t       op;
		byte_t       b1;
		word_t       got;
		bit          valid_seen;
		name     = row_name[idx];
		fb       = row_bytes[idx];
		op       = row_byte(fb, 0);
		b1       = row_byte(fb, 1);
		test_ok  = 1'b1;
		rst_seen = 1'b0;
		sent_bytes.delete();
		sent_cs.delete();
		sent_sel.delete();
		send_frame(fb);
		if (!row_resp[idx]) begin
			valid_seen = 1'b0;
			repeat (50) begin
				@(negedge clk);
				if (o_m_valid)
					valid_seen = 1'b1;
			end
			if (valid_seen || resp_q.size() != 0)
				flag_error($sformatf("%s: response given to an unknown opcode", name));
		end else begin
			while (resp_q.size() == 0)
				@(negedge clk);
			got = resp_q.pop_front();
			case (op)
				OP_VERSION:   compare_word(name, VERSION_WORD, got);
				OP_SPI:       check_spi(name, fb, got);
				OP_OVERRANGE: compare_word(name, word_t'(ovr_cycles[b1[1:0]]), got);
				OP_SPI_MODE: begin
					compare_word(name, word_t'(b1), got);
					compare_mode(name, b1[1:0], o_spi_mode);
					if (!rst_seen)
						flag_error($sformatf("%s: spi master reset pulse not seen", name));
				end
				default: flag_error($sformatf("%s: no response rule for opcode", name));
			endcase
		end
		tests_run++;
		if (!test_ok)
			tests_failed++;
		$display("test %-14s %s", name, test_ok ? "ok" : "FAILED");
	endtask

	// ------------------------------
	// output sink and spi master model
	initial begin
		rng            = 32'h1a85;
		i_m_ready      = 1'b0;
		i_spi_tx_ready = 1'b1;  // idle master
		i_spi_rx_dv    = 1'b0;
		i_spi_rx       = '0;
		last_reply     = '0;
		stalled        = 1'b0;
		held_word      = '0;
		reply_wait     = 0;
		forever begin
			@(negedge clk);
			if (stalled && (!o_m_valid || o_m_data !== held_word))
				flag_error("response word changed while waiting for ready");
			if (!o_spi_rst_n)
				rst_seen = 1'b1;
			rng       = xorshift32(rng);
			i_m_ready = rng[0] | rng[1];  // ready about 3 of 4 cycles
			if (o_m_valid && i_m_ready) begin
				if (o_m_keep !== '1 || o_m_last !== 1'b1)
					flag_error("response word without full keep and last");
				resp_q.push_back(o_m_data);
				handshakes++;
			end
			stalled   = o_m_valid && !i_m_ready;
			held_word = o_m_data;

			i_spi_rx_dv = 1'b0;
			if (o_spi_tx_dv) begin
				sent_bytes.push_back(o_spi_tx);
				sent_cs.push_back(o_spi_cs);
				sent_sel.push_back(o_spi_miso_sel);
				i_spi_tx_ready = 1'b0;
				reply_wait     = 3;
			end else if (reply_wait > 0) begin
				reply_wait--;
				if (reply_wait == 0) begin
					rng         = xorshift32(rng);
					i_spi_rx    = rng[7:0];
					i_spi_rx_dv = 1'b1;
					last_reply  = rng[7:0];
				end
			end else begin
				i_spi_tx_ready = 1'b1;
			end
		end
	end

	// ------------------------------
	// main sequence
	initial begin
		int i;
		i_s_valid   = 1'b0;
		i_s_data    = '0;
		i_overrange = '0;
		fill_table();
		@(posedge rstn);
		@(negedge clk);
		if (o_s_ready !== 1'b1 || o_m_valid !== 1'b0 || o_spi_tx_dv !== 1'b0 ||
				o_spi_cs !== '1 || o_spi_rst_n !== 1'b1)
			flag_error("outputs not in their reset state after reset");
		for (i = 0; i < NUM_ADC_INPUTS; i++)
			drive_overrange(i, ovr_cycles[i]);
		for (i = 0; i < NUM_ROWS; i++)
			run_test(i);
		repeat (20) @(negedge clk);
		if (resp_q.size() != 0 || handshakes != expected_resp) begin
			$display("%0d response words taken, %0d expected", handshakes, expected_resp);
			errors++;
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout, run not finished after %0d cycles", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
//------------------------------
// tb_clk_gen
// 4 ns clock and an eight-cycle low reset
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	initial begin
		rstn = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;  // release away from the active edge
	end

endmodule

`default_nettype wire

// ==== hw/cmd_processor.sv ====
//------------------------------
// cmd_processor
// decodes eight-byte commands from the byte stream and
// answers each with one 32-bit word
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module cmd_processor (
	input  wire                                  clk,
	input  wire                                  rstn,
	// command byte stream
	input  wire                                  i_s_valid,
	input  wire  cmd_pkg::byte_t                 i_s_data,
	output logic                                 o_s_ready,
	// response word stream
	output logic                                 o_m_valid,
	output cmd_pkg::word_t                       o_m_data,
	output logic [cmd_pkg::KEEP_BITS-1:0]        o_m_keep,
	output logic                                 o_m_last,
	input  wire                                  i_m_ready,
	// external spi master
	output cmd_pkg::byte_t                       o_spi_tx,
	output logic                                 o_spi_tx_dv,
	input  wire                                  i_spi_tx_ready,
	input  wire                                  i_spi_rx_dv,
	input  wire  cmd_pkg::byte_t                 i_spi_rx,
	output logic [spi_pkg::NUM_CHIPS-1:0]        o_spi_cs,
	output spi_pkg::spi_mode_t                   o_spi_mode,
	output logic                                 o_spi_rst_n,
	output spi_pkg::chip_sel_t                   o_spi_miso_sel,
	// adc overrange flags
	input  wire  [cmd_pkg::NUM_ADC_INPUTS-1:0]   i_overrange
);

	import cmd_pkg::*;
	import spi_pkg::*;

	typedef enum logic [1:0] {D_RECEIVE, D_DECODE, D_SPI, D_RESPOND} disp_state_e;

	disp_state_e dstate;
	frame_t      frame;
	logic        frame_valid;
	opcode_e     opcode;
	logic        spi_start;
	logic        spi_done;
	logic [2:0]  spi_nbytes;
	byte_t       spi_tx_bytes [MAX_SPI_BYTES];
	byte_t       spi_rx_byte;
	logic        mode_wr;
	count_t      ovr_count;

	cmd_receiver i_cmd_receiver (
		.clk           (clk),
		.rstn          (rstn),
		.i_s_valid     (i_s_valid),
		.i_s_data      (i_s_data),
		.i_enable      (dstate == D_RECEIVE),
		.o_s_ready     (o_s_ready),
		.o_frame       (frame),
		.o_frame_valid (frame_valid)
	);

	// ------------------------------
	// frame fields
	assign opcode     = opcode_e'(frame[0]);
	assign spi_start  = (dstate == D_DECODE) && (opcode == OP_SPI);
	assign mode_wr    = (dstate == D_DECODE) && (opcode == OP_SPI_MODE);
	assign spi_nbytes = (frame[7] > 8'd7) ? 3'd7 : frame[7][2:0];  // saturate, seq clamps

	always_comb begin
		for (int i = 0; i < MAX_SPI_BYTES; i++)
			spi_tx_bytes[i] = frame[i + 2];  // data in bytes 2..5
	end

	spi_sequencer i_spi_sequencer (
		.clk            (clk),
		.rstn           (rstn),
		.i_start        (spi_start),
		.i_chip         (frame[1][2:0]),
		.i_nbytes       (spi_nbytes),
		.i_tx_bytes     (spi_tx_bytes),
		.i_spi_tx_ready (i_spi_tx_ready),
		.i_spi_rx_dv    (i_spi_rx_dv),
		.i_spi_rx       (i_spi_rx),
		.o_spi_tx       (o_spi_tx),
		.o_spi_tx_dv    (o_spi_tx_dv),
		.o_spi_cs       (o_spi_cs),
		.o_spi_miso_sel (o_spi_miso_sel),
		.o_done         (spi_done),
		.o_rx_byte      (spi_rx_byte)
	);

	status_regs i_status_regs (
		.clk         (clk),
		.rstn        (rstn),
		.i_mode_wr   (mode_wr),
		.i_mode      (frame[1][1:0]),
		.i_overrange (i_overrange),
		.i_adc_sel   (frame[1][1:0]),
		.o_spi_mode  (o_spi_mode),
		.o_spi_rst_n (o_spi_rst_n),
		.o_count     (ovr_count)
	);

	// ------------------------------
	// dispatch
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			dstate    <= D_RECEIVE;
			o_m_valid <= 1'b0;
		end else begin
			case (dstate)
				D_RECEIVE: if (frame_valid)
					dstate <= D_DECODE;
				D_DECODE: begin
					case (opcode)
						OP_VERSION, OP_SPI_MODE, OP_OVERRANGE: begin
							o_m_valid <= 1'b1;
							dstate    <= D_RESPOND;
						end
						OP_SPI:  dstate <= D_SPI;
						default: dstate <= D_RECEIVE;  // unknown, no answer
					endcase
				end
				D_SPI: if (spi_done) begin
					o_m_valid <= 1'b1;
					dstate    <= D_RESPOND;
				end
				D_RESPOND: if (i_m_ready) begin
					o_m_valid <= 1'b0;
					dstate    <= D_RECEIVE;
				end
				default: dstate <= D_RECEIVE;
			endcase
		end
	end

	// response word
	always_ff @(posedge clk) begin
		if (dstate == D_DECODE) begin
			case (opcode)
				OP_VERSION:   o_m_data <= FW_VERSION;
				OP_SPI_MODE:  o_m_data <= word_t'(frame[1]);
				OP_OVERRANGE: o_m_data <= ovr_count;
				default:      o_m_data <= o_m_data;
			endcase
		end else if (dstate == D_SPI && spi_done) begin
			o_m_data <= word_t'(spi_rx_byte);
		end
	end

	assign o_m_keep = '1;    // single full word
	assign o_m_last = 1'b1;

	a_word_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data)))
		else $error("response word changed while stalled");

endmodule

`default_nettype wire

// ==== hw/status_regs.sv ====
//------------------------------
// status_regs
// spi mode register with master reset pulse,
// and per-input overrange cycle counters
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module status_regs (
	input  wire                                  clk,
	input  wire                                  rstn,
	input  wire                                  i_mode_wr,
	input  wire  spi_pkg::spi_mode_t             i_mode,
	input  wire  [cmd_pkg::NUM_ADC_INPUTS-1:0]   i_overrange,
	input  wire  cmd_pkg::adc_sel_t              i_adc_sel,
	output spi_pkg::spi_mode_t                   o_spi_mode,
	output logic                                 o_spi_rst_n,
	output cmd_pkg::count_t                      o_count
);

	import cmd_pkg::*;
	import spi_pkg::*;

	spi_mode_t mode_q;
	count_t    cnt_q [NUM_ADC_INPUTS];

	// ------------------------------
	// spi mode
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			mode_q      <= '0;
			o_spi_rst_n <= 1'b1;
		end else begin
			o_spi_rst_n <= !i_mode_wr;  // master restarts in new mode
			if (i_mode_wr)
				mode_q <= i_mode;
		end
	end

	assign o_spi_mode = mode_q;

	// ------------------------------
	// overrange counters
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < NUM_ADC_INPUTS; i++)
				cnt_q[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_ADC_INPUTS; i++) begin
				if (i_overrange[i])
					cnt_q[i] <= cnt_q[i] + 1'b1;  // one per flagged cycle
			end
		end
	end

	assign o_count = cnt_q[i_adc_sel];

endmodule

`default_nettype wire

// ==== hw/spi_sequencer.sv ====
//------------------------------
// spi_sequencer
// runs one chip-selected transaction of up to four
// bytes through the external spi master
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_sequencer (
	input  wire                              clk,
	input  wire                              rstn,
	input  wire                              i_start,
	input  wire  spi_pkg::chip_sel_t         i_chip,
	input  wire  [2:0]                       i_nbytes,
	input  wire  cmd_pkg::byte_t             i_tx_bytes [spi_pkg::MAX_SPI_BYTES],
	input  wire                              i_spi_tx_ready,
	input  wire                              i_spi_rx_dv,
	input  wire  cmd_pkg::byte_t             i_spi_rx,
	output cmd_pkg::byte_t                   o_spi_tx,
	output logic                             o_spi_tx_dv,
	output logic [spi_pkg::NUM_CHIPS-1:0]    o_spi_cs,
	output spi_pkg::chip_sel_t               o_spi_miso_sel,
	output logic                             o_done,
	output cmd_pkg::byte_t                   o_rx_byte
);

	import cmd_pkg::*;
	import spi_pkg::*;

	localparam int WAIT_W = $clog2(CS_HOLD_CYCLES);

	spi_state_e        state;
	logic [WAIT_W-1:0] wait_cnt;   // cs setup and hold timer
	logic [1:0]        byte_idx;   // byte being sent
	logic [1:0]        last_idx;   // index of final byte
	logic [1:0]        last_next;
	byte_t             tx_q [MAX_SPI_BYTES];

	// byte count clamped to 1..MAX_SPI_BYTES
	always_comb begin
		if (i_nbytes == 3'd0)
			last_next = 2'd0;
		else if (i_nbytes > 3'(MAX_SPI_BYTES))
			last_next = 2'(MAX_SPI_BYTES - 1);
		else
			last_next = 2'(i_nbytes - 3'd1);
	end

	// ------------------------------
	// control
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= SPI_IDLE;
			wait_cnt       <= '0;
			byte_idx       <= '0;
			last_idx       <= '0;
			o_spi_tx_dv    <= 1'b0;
			o_spi_cs       <= '1;  // all deselected
			o_spi_miso_sel <= '0;
			o_done         <= 1'b0;
		end else begin
			o_spi_tx_dv <= 1'b0;
			o_done      <= 1'b0;
			case (state)
				SPI_IDLE: if (i_start) begin
					o_spi_cs       <= ~(NUM_CHIPS'(1) << i_chip);
					o_spi_miso_sel <= i_chip;
					last_idx       <= last_next;
					byte_idx       <= '0;
					wait_cnt       <= '0;
					state          <= SPI_CS_SETUP;
				end
				SPI_CS_SETUP: begin
					if (wait_cnt == WAIT_W'(CS_SETUP_CYCLES - 1)) begin
						wait_cnt <= '0;
						state    <= SPI_WAIT_READY;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				SPI_WAIT_READY: if (i_spi_tx_ready) begin
					o_spi_tx_dv <= 1'b1;
					state       <= SPI_SEND;
				end
				SPI_SEND: begin  // master sees tx_dv this cycle
					if (byte_idx == last_idx) begin
						state <= SPI_WAIT_RX;
					end else begin
						byte_idx <= byte_idx + 2'd1;
						state    <= SPI_WAIT_READY;
					end
				end
				SPI_WAIT_RX: if (i_spi_rx_dv)
					state <= SPI_CS_HOLD;
				SPI_CS_HOLD: begin
					if (wait_cnt == WAIT_W'(CS_HOLD_CYCLES - 1)) begin
						wait_cnt <= '0;
						o_spi_cs <= '1;
						o_done   <= 1'b1;
						state    <= SPI_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// ------------------------------
	// data path
	always_ff @(posedge clk) begin
		if (state == SPI_IDLE && i_start)
			tx_q <= i_tx_bytes;
		if (state == SPI_WAIT_READY && i_spi_tx_ready)
			o_spi_tx <= tx_q[byte_idx];
		if (state == SPI_WAIT_RX && i_spi_rx_dv)
			o_rx_byte <= i_spi_rx;  // reply to the final byte
	end

	a_one_cs: assert property (@(posedge clk) disable iff (!rstn)
		$countones(~o_spi_cs) <= 1)
		else $error("more than one chip select low");

	a_dv_pulse: assert property (@(posedge clk) disable iff (!rstn)
		o_spi_tx_dv |=> !o_spi_tx_dv)
		else $error("tx_dv held for two cycles");

endmodule

`default_nettype wire

// ==== hw/cmd_receiver.sv ====
//------------------------------
// cmd_receiver
// gathers eight stream bytes into one command frame
//------------------------------

`timescale 1ns/1ps
`default_nettype none

module cmd_receiver (
	input  wire                   clk,
	input  wire                   rstn,
	input  wire                   i_s_valid,
	input  wire  cmd_pkg::byte_t  i_s_data,
	input  wire                   i_enable,
	output logic                  o_s_ready,
	output cmd_pkg::frame_t       o_frame,
	output logic                  o_frame_valid
);

	import cmd_pkg::*;

	logic [2:0] byte_cnt;    // next slot in the frame
	logic       frame_done;  // frame complete, stalled until released
	logic       take;

	assign o_s_ready = i_enable && !frame_done;
	assign take      = i_s_valid && o_s_ready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt      <= '0;
			frame_done    <= 1'b0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= 1'b0;
			if (!i_enable)
				frame_done <= 1'b0;  // dispatcher has the frame
			if (take) begin
				byte_cnt <= byte_cnt + 3'd1;  // wraps after byte 7
				if (byte_cnt == 3'(FRAME_BYTES - 1)) begin
					frame_done    <= 1'b1;
					o_frame_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			o_frame[byte_cnt] <= i_s_data;
	end

	// source must hold the byte until it is taken
	a_data_hold: assert property (@(posedge clk) disable iff (!rstn)
		(i_s_valid && !o_s_ready) |=> $stable(i_s_data))
		else $error("input byte changed while stalled");

endmodule

`default_nettype wire

// ==== hw/spi_pkg.sv ====
//------------------------------
// spi package
// sequencer states, chip selects and cs timing
//------------------------------

`default_nettype none

package spi_pkg;

	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_CS_SETUP,    // cs low, settling
		SPI_WAIT_READY,  // wait for master tx_ready
		SPI_SEND,        // tx_dv pulse out
		SPI_WAIT_RX,     // wait for the reply to the last byte
		SPI_CS_HOLD      // keep cs low a while
	} spi_state_e;

	localparam int NUM_CHIPS     = 8;
	localparam int MAX_SPI_BYTES = 4;

	typedef logic [2:0] chip_sel_t;
	typedef logic [1:0] spi_mode_t;

	localparam int CS_SETUP_CYCLES = 6;   // cs low before first byte
	localparam int CS_HOLD_CYCLES  = 16;  // cs low after the read byte

endpackage

`default_nettype wire

// ==== hw/cmd_pkg.sv ====
//------------------------------
// command package
// opcodes, frame layout and stream widths of the
// digitizer command processor
//------------------------------

`default_nettype none

package cmd_pkg;

	// ------------------------------
	// command opcodes, byte 0 of a frame
	typedef enum logic [7:0] {
		OP_VERSION   = 8'd2,  // read firmware version
		OP_SPI       = 8'd3,  // spi transaction
		OP_SPI_MODE  = 8'd4,  // set spi mode, resets the master
		OP_OVERRANGE = 8'd7   // read one overrange counter
	} opcode_e;

	// ------------------------------
	// stream and frame layout
	localparam int BYTE_BITS   = 8;
	localparam int WORD_BITS   = 32;
	localparam int KEEP_BITS   = WORD_BITS / BYTE_BITS;  // one keep bit per byte
	localparam int FRAME_BYTES = 8;

	typedef logic [BYTE_BITS-1:0] byte_t;
	typedef byte_t                frame_t [FRAME_BYTES];  // byte 0 is the opcode
	typedef logic [WORD_BITS-1:0] word_t;

	localparam word_t FW_VERSION = 32'd12;

	// ------------------------------
	// overrange monitoring
	localparam int NUM_ADC_INPUTS = 4;  // ora0, ora1, orb0, orb1

	typedef logic [1:0]  adc_sel_t;
	typedef logic [31:0] count_t;

endpackage

`default_nettype wire
